//--- rtl/noc_perf_pkg.sv
/*
  NoC performance test package.
  Run constants and the flit, lane statistics and result structs.
*/
package noc_perf_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Run constants
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int LINK_WIDTH    = 16;
  localparam int TS_WIDTH      = LINK_WIDTH; // Timestamps travel as flit data.
  localparam int PKT_COUNT     = 64;
  localparam int WARMUP_COUNT  = 16;
  localparam int CNT_WIDTH     = 24;
  localparam int LANE0_LATENCY = 2;
  localparam int LANE1_LATENCY = 5;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                  valid;
    logic [LINK_WIDTH-1:0] data;
  } link_flit_s;

  // Result of one lane for one run.
  typedef struct packed {
    logic [CNT_WIDTH-1:0] received;
    logic [CNT_WIDTH-1:0] total_delay;
    logic                 done;
  } lane_stats_s;

  typedef struct packed {
    logic [CNT_WIDTH-1:0] received;
    logic [CNT_WIDTH-1:0] total_delay;
  } perf_result_s;

endpackage

//--- rtl/noc_traffic_gen.sv
/*
  Traffic generator.
  Sends PKT_COUNT flits per run, each stamped with the local cycle count.
*/
`timescale 1ns/10ps

module noc_traffic_gen
  (input  logic                     link_clk_i
  ,input  logic                     link_reset_i
  ,input  logic                     start_i
  ,input  logic                     ready_i
  ,output noc_perf_pkg::link_flit_s flit_o
  );

  logic [noc_perf_pkg::TS_WIDTH-1:0]  cycle_r;
  logic [noc_perf_pkg::CNT_WIDTH-1:0] sent_r;
  logic                               active_r;
  logic [noc_perf_pkg::TS_WIDTH-1:0]  stamp_r;
  logic                               accept;

  assign accept = active_r && ready_i;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      cycle_r  <= '0;
      sent_r   <= '0;
      active_r <= 1'b0;
    end
    else if (start_i)
    begin
      cycle_r  <= '0; // Kept in step with the client's counter.
      sent_r   <= '0;
      active_r <= 1'b1;
    end
    else
    begin
      cycle_r <= cycle_r + 1'b1;
      if (accept)
      begin
        sent_r <= sent_r + 1'b1;
        if (sent_r == noc_perf_pkg::PKT_COUNT - 1)
          active_r <= 1'b0;
      end
    end
  end

  // The stamp is the cycle in which a flit is first offered, so it holds under stall.
  always_ff @(posedge link_clk_i)
  begin
    if (start_i)
      stamp_r <= '0;
    else if (accept)
      stamp_r <= cycle_r + 1'b1;
  end

  assign flit_o.valid = active_r;
  assign flit_o.data  = stamp_r;

  // An offered flit stays offered and unchanged until it is taken.
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    flit_o.valid && !ready_i |=> flit_o.valid && $stable(flit_o.data));

endmodule

//--- rtl/noc_link_channel.sv
/*
  Fixed latency link channel.
  LATENCY_P register stages that move forward together and freeze as a whole.
*/
`timescale 1ns/10ps

module noc_link_channel
 #(parameter int LATENCY_P = 2
  )
  (input  logic                     link_clk_i
  ,input  logic                     link_reset_i
  ,input  noc_perf_pkg::link_flit_s flit_i
  ,output logic                     ready_o
  ,output noc_perf_pkg::link_flit_s flit_o
  ,input  logic                     ready_i
  );

  logic [LATENCY_P-1:0]                valid_r;
  logic [noc_perf_pkg::LINK_WIDTH-1:0] data_r [LATENCY_P];
  logic                                advance;

  // The pipe moves when its last stage is empty or is being drained.
  assign advance = !valid_r[LATENCY_P-1] || ready_i;
  assign ready_o = advance;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
      valid_r <= '0;
    else if (advance)
    begin
      valid_r[0] <= flit_i.valid;
      for (int i = 1; i < LATENCY_P; i++)
        valid_r[i] <= valid_r[i-1];
    end
  end

  always_ff @(posedge link_clk_i)
  begin
    if (advance)
    begin
      data_r[0] <= flit_i.data;
      for (int i = 1; i < LATENCY_P; i++)
        data_r[i] <= data_r[i-1];
    end
  end

  assign flit_o.valid = valid_r[LATENCY_P-1];
  assign flit_o.data  = data_r[LATENCY_P-1];

endmodule

//--- rtl/noc_perf_client.sv
/*
  Measuring client node.
  Counts received flits and sums the transit delay of those past warm-up.
*/
`timescale 1ns/10ps

module noc_perf_client
  (input  logic                      link_clk_i
  ,input  logic                      link_reset_i
  ,input  logic                      start_i
  ,input  logic                      stall_i
  ,input  noc_perf_pkg::link_flit_s  flit_i
  ,output logic                      ready_o
  ,output noc_perf_pkg::lane_stats_s stats_o
  );

  logic [noc_perf_pkg::TS_WIDTH-1:0]  cycle_r;
  logic [noc_perf_pkg::CNT_WIDTH-1:0] received_r;
  logic [noc_perf_pkg::CNT_WIDTH-1:0] total_delay_r;
  logic [noc_perf_pkg::CNT_WIDTH-1:0] flit_delay;
  logic                               done_r;
  logic                               rx;

  assign ready_o = !stall_i;
  assign rx      = flit_i.valid && ready_o;

  // Timestamps wrap with the counter, so the difference is taken at TS_WIDTH.
  assign flit_delay = {{(noc_perf_pkg::CNT_WIDTH - noc_perf_pkg::TS_WIDTH){1'b0}},
                       cycle_r - flit_i.data};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      cycle_r       <= '0;
      received_r    <= '0;
      total_delay_r <= '0;
      done_r        <= 1'b0;
    end
    else if (start_i)
    begin
      cycle_r       <= '0;
      received_r    <= '0;
      total_delay_r <= '0;
      done_r        <= 1'b0;
    end
    else
    begin
      cycle_r <= cycle_r + 1'b1;
      if (rx)
      begin
        received_r <= received_r + 1'b1;
        if (received_r >= noc_perf_pkg::WARMUP_COUNT)
          total_delay_r <= total_delay_r + flit_delay; // Warm-up flits are skipped.
      end
      if (received_r == noc_perf_pkg::PKT_COUNT && !done_r)
        done_r <= 1'b1;
    end
  end

  assign stats_o.received    = received_r;
  assign stats_o.total_delay = total_delay_r;
  assign stats_o.done        = done_r;

  // The generator and channel must have nothing left once the lane is done.
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    done_r && !start_i |-> !rx);

endmodule

//--- rtl/noc_perf_merge.sv
/*
  Run control and result merge.
  Starts both lanes on a request and answers with the summed lane results.
*/
`timescale 1ns/10ps

module noc_perf_merge
  (input  logic                       link_clk_i
  ,input  logic                       link_reset_i
  ,input  logic                       start_req_i
  ,output logic                       start_ack_o
  ,output logic                       run_start_o
  ,input  noc_perf_pkg::lane_stats_s  lane0_stats_i
  ,input  noc_perf_pkg::lane_stats_s  lane1_stats_i
  ,output noc_perf_pkg::perf_result_s result_o
  );

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_ACK} merge_state_e;

  merge_state_e                state_r;
  logic                        req_q;
  logic                        req_rise;
  logic                        run_start_r;
  logic                        ack_r;
  logic                        lanes_done;
  noc_perf_pkg::perf_result_s  result_r;

  assign req_rise = start_req_i && !req_q;

  // Done flags of the last run are still up while the start pulse is out.
  assign lanes_done = lane0_stats_i.done && lane1_stats_i.done && !run_start_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four-phase handshake FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      state_r     <= ST_IDLE;
      req_q       <= 1'b0;
      run_start_r <= 1'b0;
      ack_r       <= 1'b0;
    end
    else
    begin
      req_q       <= start_req_i;
      run_start_r <= 1'b0;
      case (state_r)
        ST_IDLE:
        begin
          if (req_rise)
          begin
            run_start_r <= 1'b1;
            state_r     <= ST_RUN;
          end
        end
        ST_RUN:
        begin
          if (lanes_done)
          begin
            ack_r   <= 1'b1;
            state_r <= ST_ACK;
          end
        end
        ST_ACK:
        begin
          if (!start_req_i)
          begin
            ack_r   <= 1'b0;
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // Captured once as ack rises and held while it is high.
  always_ff @(posedge link_clk_i)
  begin
    if (state_r == ST_RUN && lanes_done)
    begin
      result_r.received    <= lane0_stats_i.received + lane1_stats_i.received;
      result_r.total_delay <= lane0_stats_i.total_delay + lane1_stats_i.total_delay;
    end
  end

  assign start_ack_o = ack_r;
  assign run_start_o = run_start_r;
  assign result_o    = result_r;

  // The outside keeps req up for the whole run.
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    !start_req_i |=> !$rose(start_ack_o));

endmodule

//--- rtl/noc_perf_top.sv
/*
  NoC performance test top level.
  One run controller and two lanes of generator, channel and client.
*/
`timescale 1ns/10ps

module noc_perf_top
  (input  logic                       link_clk_i
  ,input  logic                       link_reset_i
  ,input  logic                       start_req_i
  ,output logic                       start_ack_o
  ,input  logic [1:0]                 lane_stall_i
  ,output noc_perf_pkg::perf_result_s result_o
  );

  logic                      run_start;
  noc_perf_pkg::link_flit_s  lane0_gen_flit, lane1_gen_flit;
  noc_perf_pkg::link_flit_s  lane0_rx_flit, lane1_rx_flit;
  logic                      lane0_chan_ready, lane1_chan_ready;
  logic                      lane0_client_ready, lane1_client_ready;
  noc_perf_pkg::lane_stats_s lane0_stats, lane1_stats;

  noc_perf_merge i_noc_perf_merge
    (.link_clk_i   (link_clk_i)
    ,.link_reset_i (link_reset_i)
    ,.start_req_i  (start_req_i)
    ,.start_ack_o  (start_ack_o)
    ,.run_start_o  (run_start)
    ,.lane0_stats_i(lane0_stats)
    ,.lane1_stats_i(lane1_stats)
    ,.result_o     (result_o)
    );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane 0
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noc_traffic_gen i_lane0_gen
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.start_i     (run_start)
    ,.ready_i     (lane0_chan_ready)
    ,.flit_o      (lane0_gen_flit)
    );

  noc_link_channel #(.LATENCY_P(noc_perf_pkg::LANE0_LATENCY)) i_lane0_chan
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.flit_i      (lane0_gen_flit)
    ,.ready_o     (lane0_chan_ready)
    ,.flit_o      (lane0_rx_flit)
    ,.ready_i     (lane0_client_ready)
    );

  noc_perf_client i_lane0_client
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.start_i     (run_start)
    ,.stall_i     (lane_stall_i[0])
    ,.flit_i      (lane0_rx_flit)
    ,.ready_o     (lane0_client_ready)
    ,.stats_o     (lane0_stats)
    );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane 1
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noc_traffic_gen i_lane1_gen
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.start_i     (run_start)
    ,.ready_i     (lane1_chan_ready)
    ,.flit_o      (lane1_gen_flit)
    );

  noc_link_channel #(.LATENCY_P(noc_perf_pkg::LANE1_LATENCY)) i_lane1_chan
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.flit_i      (lane1_gen_flit)
    ,.ready_o     (lane1_chan_ready)
    ,.flit_o      (lane1_rx_flit)
    ,.ready_i     (lane1_client_ready)
    );

  noc_perf_client i_lane1_client
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.start_i     (run_start)
    ,.stall_i     (lane_stall_i[1])
    ,.flit_i      (lane1_rx_flit)
    ,.ready_o     (lane1_client_ready)
    ,.stats_o     (lane1_stats)
    );

endmodule

//--- tests/noc_perf_tb.sv
/*
  Testbench for the NoC performance test subsystem.
  Runs the four-phase handshake with and without lane stalls and checks the merged result.
*/
`timescale 1ns/10ps

module noc_perf_tb
 #(parameter int SEED          = 30250
  ,parameter int RUN_TIMEOUT   = 4000
  ,parameter int CHECK_TIMEOUT = 20
  );

  typedef enum int {MODE_NONE, MODE_RANDOM, MODE_LANE1} stall_mode_e;

  logic                       link_clk_i = 1'b0;
  logic                       link_reset_i;
  logic                       start_req_i;
  logic                       start_ack_o;
  logic [1:0]                 lane_stall_i;
  noc_perf_pkg::perf_result_s result_o;

  stall_mode_e                run_mode;
  noc_perf_pkg::perf_result_s expected;
  int                         checks_done = 0;
  logic                       ack_prev = 1'b0;

  noc_perf_top i_noc_perf_top
    (.link_clk_i  (link_clk_i)
    ,.link_reset_i(link_reset_i)
    ,.start_req_i (start_req_i)
    ,.start_ack_o (start_ack_o)
    ,.lane_stall_i(lane_stall_i)
    ,.result_o    (result_o)
    );

  always #10 link_clk_i = ~link_clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string name, input longint got, input longint exp);
    abort_run($sformatf("error at time %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Every flit of a free lane arrives exactly one channel latency after it was stamped.
  // Stalls only hold flits longer, so this delay is the lower bound in the stalled modes.
  function automatic noc_perf_pkg::perf_result_s expected_result(input stall_mode_e mode);
    noc_perf_pkg::perf_result_s res;
    int                         lat [2];
    int                         count;
    int                         delay;
    lat[0] = noc_perf_pkg::LANE0_LATENCY;
    lat[1] = noc_perf_pkg::LANE1_LATENCY;
    count  = 0;
    delay  = 0;
    for (int lane = 0; lane < 2; lane++)
    begin
      for (int k = 0; k < noc_perf_pkg::PKT_COUNT; k++)
      begin
        count++;
        if (k >= noc_perf_pkg::WARMUP_COUNT)
          delay += lat[lane]; // Only flits past warm-up count.
      end
    end
    res.received    = count[noc_perf_pkg::CNT_WIDTH-1:0];
    res.total_delay = delay[noc_perf_pkg::CNT_WIDTH-1:0];
    return res;
  endfunction

  // Checks the result once, half a cycle after ack rises.
  always @(negedge link_clk_i)
  begin
    if (link_reset_i)
      ack_prev = 1'b0;
    else
    begin
      if (start_ack_o && !ack_prev)
      begin
        assert (result_o.received == expected.received)
        else
          value_error("result_o.received", result_o.received, expected.received);
        if (run_mode == MODE_NONE)
        begin
          assert (result_o.total_delay == expected.total_delay)
          else
            value_error("result_o.total_delay", result_o.total_delay, expected.total_delay);
        end
        else
        begin
          assert (result_o.total_delay >= expected.total_delay)
          else
            abort_run($sformatf(
              "error at time %0t: result_o.total_delay is %0d, expected at least %0d",
              $time, result_o.total_delay, expected.total_delay));
        end
        checks_done++;
      end
      ack_prev = start_ack_o;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_stalls(input stall_mode_e mode);
    case (mode)
      MODE_RANDOM: lane_stall_i = 2'($urandom);
      MODE_LANE1:  lane_stall_i = {1'($urandom), 1'b0};
      default:     lane_stall_i = 2'b00;
    endcase
  endtask

  // One full handshake. Called 2 ns after a rising edge.
  task automatic run_once(input stall_mode_e mode);
    int cycles;
    int checks_before;
    run_mode      = mode;
    expected      = expected_result(mode);
    checks_before = checks_done;
    start_req_i   = 1'b1;
    cycles        = 0;
    while (!start_ack_o)
    begin
      @(posedge link_clk_i);
      #2;
      drive_stalls(mode);
      cycles++;
      if (cycles > RUN_TIMEOUT)
        abort_run("timeout: start_ack_o never rose after the run request");
    end
    lane_stall_i = 2'b00;

    cycles = 0;
    while (checks_done == checks_before)
    begin
      @(posedge link_clk_i);
      #2;
      cycles++;
      if (cycles > CHECK_TIMEOUT)
        abort_run("timeout: the result was never checked after ack rose");
    end

    start_req_i = 1'b0;
    cycles      = 0;
    while (start_ack_o)
    begin
      @(posedge link_clk_i);
      #2;
      cycles++;
      if (cycles > CHECK_TIMEOUT)
        abort_run("timeout: start_ack_o stayed high after the request dropped");
    end

    // Ack must stay down while no new request is made.
    for (int i = 0; i < 5; i++)
    begin
      @(posedge link_clk_i);
      #2;
      assert (!start_ack_o) else value_error("start_ack_o", start_ack_o, 0);
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    link_reset_i = 1'b1;
    start_req_i  = 1'b0;
    lane_stall_i = 2'b00;
    run_mode     = MODE_NONE;
    expected     = '0;
    repeat (2) @(posedge link_clk_i);
    #2;
    link_reset_i = 1'b0;

    for (int i = 0; i < 10; i++)
    begin
      @(posedge link_clk_i);
      #2;
      assert (!start_ack_o) else value_error("start_ack_o", start_ack_o, 0);
    end

    run_once(MODE_NONE);
    run_once(MODE_RANDOM);
    run_once(MODE_LANE1);
    run_once(MODE_NONE);    // Counters must clear on start.

    if (checks_done == 4)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
      abort_run($sformatf("only %0d of 4 runs were checked", checks_done));
  end

endmodule

//--- filelist.f
rtl/noc_perf_pkg.sv
rtl/noc_traffic_gen.sv
rtl/noc_link_channel.sv
rtl/noc_perf_client.sv
rtl/noc_perf_merge.sv
rtl/noc_perf_top.sv
tests/noc_perf_tb.sv

//--- Makefile
# Verilator build and run for the NoC performance test.

VERILATOR ?= verilator
TOP       ?= noc_perf_tb
RTL_TOP   ?= noc_perf_top
SEED      ?= 30250
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
PASS_MSG  := Test completed successfully

RTL_SRCS := rtl/noc_perf_pkg.sv \
            rtl/noc_traffic_gen.sv \
            rtl/noc_link_channel.sv \
            rtl/noc_perf_client.sv \
            rtl/noc_perf_merge.sv \
            rtl/noc_perf_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
